// File: all.f
+incdir+design
design/fft_stage_pkg.sv
design/sample_ram.sv
design/twiddle_rom.sv
design/butterfly.sv
design/stage_ctrl.sv
design/fft_stage_top.sv
tb/tb_fft_stage.sv

// File: design/butterfly.sv
`include "fft_stage_macros.svh"
`default_nettype none

module butterfly
    import fft_stage_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire cplx_t   data_i,
    input  wire rd_tag_t tag_i,
    input  wire cplx_t   tw_i,
    output bf_res_t      res_o
);

    localparam int PW = 2 * `SAMPLE_W;

    cplx_t                    a_q;
    logic                     s1_valid;
    logic [`FFT_AW-2:0]       s1_k;
    cplx_t                    s1_sum;
    cplx_t                    s1_dif;
    cplx_t                    s1_tw;
    logic                     p_valid;
    logic [`FFT_AW-2:0]       p_k;
    logic signed [PW-1:0]     p_rr;
    logic signed [PW-1:0]     p_ii;
    logic signed [PW-1:0]     p_ri;
    logic signed [PW-1:0]     p_ir;
    logic signed [`SAMPLE_W:0] sum_re;
    logic signed [`SAMPLE_W:0] sum_im;
    logic signed [`SAMPLE_W:0] dif_re;
    logic signed [`SAMPLE_W:0] dif_im;
    logic signed [PW-1:0]     y_re;
    logic signed [PW-1:0]     y_im;
    logic                     take_a;
    logic                     take_b;

    assign take_a = tag_i.en && (tag_i.kind == KIND_A);
    assign take_b = tag_i.en && (tag_i.kind == KIND_B);

    // one extra bit so the halving never overflows
    always_comb begin
        sum_re = a_q.re + data_i.re;
        sum_im = a_q.im + data_i.im;
        dif_re = a_q.re - data_i.re;
        dif_im = a_q.im - data_i.im;
        // each product term is truncated on its own before the add
        y_re = (p_rr >>> `TW_FRAC) - (p_ii >>> `TW_FRAC);
        y_im = (p_ri >>> `TW_FRAC) + (p_ir >>> `TW_FRAC);
    end

    // ------------------------------
    // data path
    // ------------------------------

    always_ff @(posedge clk) begin
        if (take_a) begin
            a_q <= data_i;
        end
        s1_k      <= tag_i.k;
        s1_sum.re <= sum_re[`SAMPLE_W:1];
        s1_sum.im <= sum_im[`SAMPLE_W:1];
        s1_dif.re <= dif_re[`SAMPLE_W:1];
        s1_dif.im <= dif_im[`SAMPLE_W:1];
        s1_tw     <= tw_i;
        p_k       <= s1_k;
        p_rr      <= s1_dif.re * s1_tw.re;
        p_ii      <= s1_dif.im * s1_tw.im;
        p_ri      <= s1_dif.re * s1_tw.im;
        p_ir      <= s1_dif.im * s1_tw.re;
    end

    // ------------------------------
    // valid pipe and result mux
    // ------------------------------

    // x goes out first, y one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            p_valid  <= 1'b0;
            res_o    <= '0;
        end else begin
            s1_valid <= take_b;
            p_valid  <= s1_valid;
            if (p_valid) begin
                res_o <= '{valid: 1'b1, upper: 1'b1, k: p_k,
                           data: '{re: y_re[`SAMPLE_W-1:0], im: y_im[`SAMPLE_W-1:0]}};
            end else if (s1_valid) begin
                res_o <= '{valid: 1'b1, upper: 1'b0, k: s1_k, data: s1_sum};
            end else begin
                res_o.valid <= 1'b0;
            end
        end
    end

    a_pair_order: assert property (@(posedge clk) disable iff (!rst_n)
        take_b |-> $past(take_a) && ($past(tag_i.k) == tag_i.k))
        else $error("operand b without a matching operand a");

    // a y without its x means two pairs collided in the pipe
    a_y_follows_x: assert property (@(posedge clk) disable iff (!rst_n)
        (res_o.valid && res_o.upper) |-> $past(res_o.valid && !res_o.upper))
        else $error("y result not preceded by its x result");

endmodule

`default_nettype wire

// File: design/fft_stage_macros.svh
`ifndef FFT_STAGE_MACROS_SVH
`define FFT_STAGE_MACROS_SVH

`default_nettype none

// ------------------------------
// transform size
// ------------------------------

// number of complex points in one frame
`define FFT_N 16

// address width of a buffer, log2 of FFT_N
`define FFT_AW 4

// ------------------------------
// number format
// ------------------------------

// width of the real or the imaginary part, Q1.14
`define SAMPLE_W 16

// fraction bits of a twiddle factor
`define TW_FRAC 14

`default_nettype wire

`endif

// File: design/fft_stage_pkg.sv
`include "fft_stage_macros.svh"
`default_nettype none

package fft_stage_pkg;

    // complex sample, real part in the upper half
    typedef struct packed {
        logic signed [`SAMPLE_W-1:0] re;
        logic signed [`SAMPLE_W-1:0] im;
    } cplx_t;

    // which operand of a butterfly a read returns
    typedef enum logic {
        KIND_A = 1'b0,
        KIND_B = 1'b1
    } sample_kind_e;

    // tag that travels with each compute read
    typedef struct packed {
        logic               en;
        sample_kind_e       kind;
        logic [`FFT_AW-2:0] k;
    } rd_tag_t;

    // butterfly output, upper selects k or k+N/2
    typedef struct packed {
        logic               valid;
        logic               upper;
        logic [`FFT_AW-2:0] k;
        cplx_t              data;
    } bf_res_t;

    typedef enum logic [2:0] {
        ST_LOAD,
        ST_READ_A,
        ST_READ_B,
        ST_FLUSH,
        ST_DRAIN
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: design/fft_stage_top.sv
`include "fft_stage_macros.svh"
`default_nettype none

module fft_stage_top
    import fft_stage_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  in_valid_i,
    input  wire cplx_t in_data_i,
    output logic       out_valid_o,
    output cplx_t      out_data_o,
    output logic       done_o,
    output logic       busy_o
);

    logic               in_wr;
    logic [`FFT_AW-1:0] in_waddr;
    logic [`FFT_AW-1:0] in_raddr;
    cplx_t              in_rdata;
    rd_tag_t            tag;
    logic [`FFT_AW-2:0] tw_addr;
    cplx_t              tw;
    bf_res_t            res;
    logic               out_wr;
    logic [`FFT_AW-1:0] out_waddr;
    logic [`FFT_AW-1:0] out_raddr;

    // ------------------------------
    // buffers
    // ------------------------------

    sample_ram in_buf (
        .clk     (clk),
        .we_i    (in_wr),
        .waddr_i (in_waddr),
        .wdata_i (in_data_i),
        .raddr_i (in_raddr),
        .rdata_o (in_rdata)
    );

    // results come out in natural order
    sample_ram out_buf (
        .clk     (clk),
        .we_i    (out_wr),
        .waddr_i (out_waddr),
        .wdata_i (res.data),
        .raddr_i (out_raddr),
        .rdata_o (out_data_o)
    );

    // ------------------------------
    // compute
    // ------------------------------

    twiddle_rom u_twiddle (
        .clk    (clk),
        .addr_i (tw_addr),
        .tw_o   (tw)
    );

    butterfly u_bfly (
        .clk    (clk),
        .rst_n  (rst_n),
        .data_i (in_rdata),
        .tag_i  (tag),
        .tw_i   (tw),
        .res_o  (res)
    );

    stage_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (in_valid_i),
        .in_wr_o     (in_wr),
        .in_waddr_o  (in_waddr),
        .in_raddr_o  (in_raddr),
        .tag_o       (tag),
        .tw_addr_o   (tw_addr),
        .res_i       (res),
        .out_wr_o    (out_wr),
        .out_waddr_o (out_waddr),
        .out_raddr_o (out_raddr),
        .out_valid_o (out_valid_o),
        .done_o      (done_o),
        .busy_o      (busy_o)
    );

endmodule

`default_nettype wire

// File: design/sample_ram.sv
`include "fft_stage_macros.svh"
`default_nettype none

module sample_ram
    import fft_stage_pkg::*;
(
    input  wire logic              clk,

    // write port
    input  wire logic              we_i,
    input  wire logic [`FFT_AW-1:0] waddr_i,
    input  wire cplx_t             wdata_i,

    // read port, data one cycle after the address
    input  wire logic [`FFT_AW-1:0] raddr_i,
    output cplx_t                  rdata_o
);

    cplx_t mem [`FFT_N];

    // ------------------------------
    // storage
    // ------------------------------

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // read returns the old word on a same-address write
    always_ff @(posedge clk) begin
        rdata_o <= mem[raddr_i];
    end

    // ------------------------------
    // checks
    // ------------------------------

    a_waddr_known: assert property (@(posedge clk) we_i |-> !$isunknown(waddr_i))
        else $error("sample_ram write with unknown address");

endmodule

`default_nettype wire

// File: design/stage_ctrl.sv
`include "fft_stage_macros.svh"
`default_nettype none

module stage_ctrl
    import fft_stage_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst_n,

    // load side
    input  wire logic              in_valid_i,
    output logic                   in_wr_o,
    output logic [`FFT_AW-1:0]     in_waddr_o,

    // compute reads
    output logic [`FFT_AW-1:0]     in_raddr_o,
    output rd_tag_t                tag_o,
    output logic [`FFT_AW-2:0]     tw_addr_o,

    // write-back and drain
    input  wire bf_res_t           res_i,
    output logic                   out_wr_o,
    output logic [`FFT_AW-1:0]     out_waddr_o,
    output logic [`FFT_AW-1:0]     out_raddr_o,
    output logic                   out_valid_o,
    output logic                   done_o,
    output logic                   busy_o
);

    localparam logic [`FFT_AW-1:0] LAST_ADDR = `FFT_AW'(`FFT_N - 1);
    localparam logic [`FFT_AW-2:0] LAST_K    = (`FFT_AW-1)'(`FFT_N / 2 - 1);
    localparam logic [`FFT_AW:0]   N_WR      = (`FFT_AW+1)'(`FFT_N);

    ctrl_state_e        state_q;
    ctrl_state_e        state_d;
    logic [`FFT_AW-1:0] load_cnt;
    logic [`FFT_AW-2:0] k_cnt;
    logic [`FFT_AW:0]   wr_cnt;
    logic [`FFT_AW-1:0] drain_cnt;
    logic               rd_a;
    logic               rd_b;

    assign rd_a    = (state_q == ST_READ_A);
    assign rd_b    = (state_q == ST_READ_B);
    assign busy_o  = (state_q != ST_LOAD);

    // strobes outside the load phase are dropped here
    assign in_wr_o    = in_valid_i && (state_q == ST_LOAD);
    assign in_waddr_o = load_cnt;

    // b sits N/2 above a, so the top address bit is the operand kind
    assign in_raddr_o = {rd_b, k_cnt};
    assign tw_addr_o  = k_cnt;

    // results map straight to their output address
    assign out_wr_o    = res_i.valid;
    assign out_waddr_o = {res_i.upper, res_i.k};
    assign out_raddr_o = drain_cnt;

    // ------------------------------
    // next state
    // ------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_LOAD:   if (in_wr_o && (load_cnt == LAST_ADDR)) state_d = ST_READ_A;
            ST_READ_A: state_d = ST_READ_B;
            ST_READ_B: state_d = (k_cnt == LAST_K) ? ST_FLUSH : ST_READ_A;
            ST_FLUSH:  if (wr_cnt == N_WR) state_d = ST_DRAIN;
            ST_DRAIN:  if (drain_cnt == LAST_ADDR) state_d = ST_LOAD;
            default:   state_d = ST_LOAD;
        endcase
    end

    // ------------------------------
    // state, counters, tags
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= ST_LOAD;
            load_cnt    <= '0;
            k_cnt       <= '0;
            wr_cnt      <= '0;
            drain_cnt   <= '0;
            tag_o       <= '0;
            out_valid_o <= 1'b0;
            done_o      <= 1'b0;
        end else begin
            state_q <= state_d;
            // all counters wrap back to zero at the end of their phase
            if (in_wr_o) begin
                load_cnt <= load_cnt + 1'b1;
            end
            if (rd_b) begin
                k_cnt <= k_cnt + 1'b1;
            end
            if (state_d == ST_DRAIN && state_q == ST_FLUSH) begin
                wr_cnt <= '0;
            end else if (out_wr_o) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (state_q == ST_DRAIN) begin
                drain_cnt <= drain_cnt + 1'b1;
            end
            // tag arrives with the RAM data
            tag_o       <= '{en: rd_a || rd_b, kind: rd_b ? KIND_B : KIND_A, k: k_cnt};
            out_valid_o <= (state_q == ST_DRAIN);
            done_o      <= (state_q == ST_DRAIN) && (drain_cnt == LAST_ADDR);
        end
    end

    a_no_write_in_drain: assert property (@(posedge clk) disable iff (!rst_n)
        !(out_wr_o && out_valid_o))
        else $error("output buffer written while draining");

    a_wr_cnt_range: assert property (@(posedge clk) disable iff (!rst_n) wr_cnt <= N_WR)
        else $error("more than N results written back");

endmodule

`default_nettype wire

// File: design/twiddle_rom.sv
`include "fft_stage_macros.svh"
`default_nettype none

module twiddle_rom
    import fft_stage_pkg::*;
(
    input  wire logic              clk,
    input  wire logic [`FFT_AW-2:0] addr_i,
    output cplx_t                  tw_o
);

    cplx_t tw_d;

    // ------------------------------
    // W^k = cos(2*pi*k/N) - j*sin(2*pi*k/N)
    // ------------------------------

    // Q1.14 values rounded to nearest, +/-1.0 held as +/-16383
    always_comb begin
        case (addr_i)
            3'd0: tw_d = '{re: 16'sd16383, im: 16'sd0};
            3'd1: tw_d = '{re: 16'sd15137, im: -16'sd6270};
            3'd2: tw_d = '{re: 16'sd11585, im: -16'sd11585};
            3'd3: tw_d = '{re: 16'sd6270, im: -16'sd15137};
            3'd4: tw_d = '{re: 16'sd0, im: -16'sd16383};
            3'd5: tw_d = '{re: -16'sd6270, im: -16'sd15137};
            3'd6: tw_d = '{re: -16'sd11585, im: -16'sd11585};
            3'd7: tw_d = '{re: -16'sd15137, im: -16'sd6270};
            default: tw_d = '{re: 16'sd16383, im: 16'sd0};
        endcase
    end

    // ------------------------------
    // registered output
    // ------------------------------

    // lines up with operand b from the input buffer
    always_ff @(posedge clk) begin
        tw_o <= tw_d;
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the FFT stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fft_stage \
    --Mdir obj_dir \
    -o tb_fft_stage \
    -f all.f

# the log decides the result
./obj_dir/tb_fft_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// File: tb/fft_stage_golden.txt
// columns: in_re in_im exp_re exp_im, Q1.14 hex, one sample per line in address order
// lines 1-16 frame 0 (impulse re, ramp im), lines 17-32 frame 1 (random values)
2000 0000 1000 0400
0000 0100 0000 0500
0000 0200 0000 0600
0000 0300 0000 0700
0000 0400 0000 0800
0000 0500 0000 0900
0000 0600 0000 0A00
0000 0700 0000 0B00
0000 0800 0FFF FC00
0000 0900 FE79 FC4D
0000 0A00 FD2C FD2B
0000 0B00 FC4E FE78
0000 0C00 FC01 0000
0000 0D00 FC4E 0187
0000 0E00 FD2C 02D4
0000 0F00 FE79 03B2
04D2 FDC9 00AC 0379
0BB9 019C 0264 FB0B
F65C 054D FD15 FC92
0325 F196 05E9 FB9D
F2FB 0A9E F6BA 035B
0A28 FF6A FF1F 0339
FCF7 0C8A 022B 0253
0F3C 0457 02BC 0816
FC86 0929 0425 FA50
F90F F47A 0B23 027E
03CF F3D8 016A 0AEC
08AD 05A4 F5AE FEB7
FA7A FC19 0742 03BF
F416 0708 F842 F743
0760 F81C 0AE8 FC74
F63C 0BD6 F304 FEAD

// File: tb/tb_fft_stage.sv
`include "fft_stage_macros.svh"
`default_nettype none

module tb_fft_stage
    import fft_stage_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N       = `FFT_N;
    localparam int COLS    = 4;
    localparam int TIMEOUT = 2000;
    localparam int N_EXTRA = 4;

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid_i;
    cplx_t                in_data_i;
    logic                 out_valid_o;
    cplx_t                out_data_o;
    logic                 done_o;
    logic                 busy_o;

    // in_re in_im exp_re exp_im for each sample and frame after frame
    logic [`SAMPLE_W-1:0] golden [2*N*COLS];
    logic [31:0]          rng_state;

    fft_stage_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (in_valid_i),
        .in_data_i   (in_data_i),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o),
        .done_o      (done_o),
        .busy_o      (busy_o)
    );

    always #50 clk = ~clk;

    // ------------------------------
    // helpers
    // ------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // col 0 gives the input sample and col 2 the expected result
    function automatic cplx_t golden_sample(input int frame, input int n, input int col);
        cplx_t c;
        int    base;
        base = (frame * N + n) * COLS + col;
        c.re = golden[base];
        c.im = golden[base + 1];
        return c;
    endfunction

    task automatic check_sample(input cplx_t got, input cplx_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s, got re=%h im=%h, expected re=%h im=%h",
                     $time, what, got.re, got.im, exp.re, exp.im);
            $display("STATUS: FAIL");
            $fatal(1, "sample mismatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "flag mismatch");
        end
    endtask

    // ------------------------------
    // stimulus and response
    // ------------------------------

    task automatic load_frame(input int frame);
        int gap;
        for (int n = 0; n < N; n++) begin
            rng_state = xorshift32(rng_state);
            gap = int'(rng_state[1:0]);
            repeat (gap) begin
                @(negedge clk);
                in_valid_i = 1'b0;
            end
            @(negedge clk);
            check_flag(busy_o, 1'b0, "busy_o while loading");
            check_flag(out_valid_o, 1'b0, "out_valid_o while loading");
            in_valid_i = 1'b1;
            in_data_i  = golden_sample(frame, n, 0);
        end
        @(negedge clk);
        in_valid_i = 1'b0;
        check_flag(busy_o, 1'b1, "busy_o after the last input");
    endtask

    // strobes while busy must not reach the input buffer
    task automatic send_extra_strobes();
        for (int i = 0; i < N_EXTRA; i++) begin
            @(negedge clk);
            check_flag(busy_o, 1'b1, "busy_o during extra strobes");
            in_valid_i = 1'b1;
            in_data_i  = '{re: 16'sh7fff, im: 16'sh8000};
        end
        @(negedge clk);
        in_valid_i = 1'b0;
        in_data_i  = '0;
    endtask

    task automatic collect_frame(input int frame);
        int wait_cnt;
        wait_cnt = 0;
        while (out_valid_o !== 1'b1) begin
            check_flag(done_o, 1'b0, "done_o before the first output");
            if (wait_cnt == TIMEOUT) begin
                $display("timeout: no output within %0d cycles in frame %0d", TIMEOUT, frame);
                $display("STATUS: FAIL");
                $fatal(1, "timeout");
            end
            wait_cnt++;
            @(negedge clk);
        end
        // results come out back to back in address order
        for (int i = 0; i < N; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            check_flag(out_valid_o, 1'b1, $sformatf("out_valid_o at output %0d", i));
            check_sample(out_data_o, golden_sample(frame, i, 2),
                         $sformatf("frame %0d output %0d", frame, i));
            check_flag(done_o, (i == N - 1), $sformatf("done_o at output %0d", i));
        end
        check_flag(busy_o, 1'b0, "busy_o with done_o");
        @(negedge clk);
        check_flag(out_valid_o, 1'b0, "out_valid_o after the last output");
        check_flag(done_o, 1'b0, "done_o after the last output");
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid_i = 1'b0;
        in_data_i  = '0;
        rng_state  = 32'd74066;
        $readmemh("tb/fft_stage_golden.txt", golden);
        for (int w = 0; w < 2 * N * COLS; w++) begin
            if ($isunknown(golden[w])) begin
                $display("golden file is missing or incomplete at word %0d", w);
                $display("STATUS: FAIL");
                $fatal(1, "bad golden file");
            end
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int f = 0; f < 2; f++) begin
            load_frame(f);
            send_extra_strobes();
            collect_frame(f);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire
